//--- design/eth_mux_defs.svh
/*
 * Ethernet frame mux widths
 * port count and field widths shared by the package and the RTL
 */

`ifndef ETH_MUX_DEFS_SVH
`define ETH_MUX_DEFS_SVH

// number of receive ports
`define ETH_PORTS 4

// header field widths
`define ETH_MAC_W 48
`define ETH_TYPE_W 16

// payload beat is one byte
`define ETH_DATA_W 8

`endif

//--- design/eth_mux_pkg.sv
/*
 * Ethernet frame mux types
 * port number and frame mux state encoding
 */

`default_nettype none

`include "eth_mux_defs.svh"

package eth_mux_pkg;

    // one receive port number
    typedef logic [$clog2(`ETH_PORTS)-1:0] port_idx_t;

    // frame mux state
    typedef enum logic {
        MUX_IDLE,   // waiting for a grant
        MUX_FRAME   // forwarding payload of the locked port
    } mux_state_t;

endpackage

`default_nettype wire

//--- design/eth_port_arbiter.sv
/*
 * Ethernet port arbiter
 * round-robin choice among receive ports that offer a header
 */

`timescale 1ns/1ns
`default_nettype none

`include "eth_mux_defs.svh"

module eth_port_arbiter
    import eth_mux_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`ETH_PORTS-1:0] hdr_valid,
    input  logic                  busy,
    output port_idx_t             grant,
    output logic                  request
);

    port_idx_t last_q;
    port_idx_t pick;
    port_idx_t idx;
    logic      found;

    // search the ports after the last served one, wrapping around
    always_comb begin
        found = 1'b0;
        pick  = last_q;
        idx   = last_q;
        for (int i = 1; i <= `ETH_PORTS; i++) begin
            idx = port_idx_t'(last_q + i);
            if (!found && hdr_valid[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    // while a frame is locked the grant is the port being served
    assign grant   = busy ? last_q : pick;
    assign request = found & ~busy;

    // the mux takes the grant on this edge, so busy rises after it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // last served is the top port, so port 0 is searched first
            last_q <= port_idx_t'(`ETH_PORTS - 1);
        end else if (request) begin
            last_q <= pick;
        end
    end

    // the mux routes by its own copy, so the grant must not move under it
    grant_stable_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        busy |-> $stable(grant)
    ) else $error("grant changed while a frame is locked");

endmodule

`default_nettype wire

//--- design/eth_frame_mux.sv
/*
 * Ethernet frame mux
 * locks onto the granted port, registers its header and routes
 * its payload bytes to the output stage until the last byte
 */

`timescale 1ns/1ns
`default_nettype none

`include "eth_mux_defs.svh"

module eth_frame_mux
    import eth_mux_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  port_idx_t                              grant,
    input  logic                                   request,
    output logic                                   busy,
    input  logic [`ETH_PORTS-1:0]                  rx_hdr_valid,
    output logic [`ETH_PORTS-1:0]                  rx_hdr_ready,
    input  logic [`ETH_PORTS-1:0][`ETH_MAC_W-1:0]  rx_dest_mac,
    input  logic [`ETH_PORTS-1:0][`ETH_MAC_W-1:0]  rx_src_mac,
    input  logic [`ETH_PORTS-1:0][`ETH_TYPE_W-1:0] rx_type,
    input  logic [`ETH_PORTS-1:0][`ETH_DATA_W-1:0] rx_tdata,
    input  logic [`ETH_PORTS-1:0]                  rx_tvalid,
    output logic [`ETH_PORTS-1:0]                  rx_tready,
    input  logic [`ETH_PORTS-1:0]                  rx_tlast,
    input  logic [`ETH_PORTS-1:0]                  rx_tuser,
    output logic                                   tx_hdr_valid,
    input  logic                                   tx_hdr_ready,
    output logic [`ETH_MAC_W-1:0]                  tx_dest_mac,
    output logic [`ETH_MAC_W-1:0]                  tx_src_mac,
    output logic [`ETH_TYPE_W-1:0]                 tx_type,
    output logic [`ETH_DATA_W-1:0]                 beat_data,
    output logic                                   beat_valid,
    output logic                                   beat_last,
    output logic                                   beat_user,
    input  logic                                   ready_early
);

    mux_state_t            state_q, state_d;
    port_idx_t             sel_q, sel_d;
    logic [`ETH_PORTS-1:0] hdr_ready_q, hdr_ready_d;
    logic [`ETH_PORTS-1:0] tready_q, tready_d;
    logic                  tx_hdr_valid_q, tx_hdr_valid_d;
    logic                  hdr_load;
    logic                  cur_xfer;
    logic [`ETH_MAC_W-1:0]  dest_mac_q, src_mac_q;
    logic [`ETH_TYPE_W-1:0] type_q;

    // a byte moves from the locked port on this edge
    assign cur_xfer = (state_q == MUX_FRAME) & rx_tvalid[sel_q] & tready_q[sel_q];

    always_comb begin
        state_d  = state_q;
        sel_d    = sel_q;
        hdr_load = 1'b0;
        tready_d = '0;
        // hdr_ready holds until the port lets go of its header
        hdr_ready_d    = hdr_ready_q & rx_hdr_valid;
        tx_hdr_valid_d = tx_hdr_valid_q & ~tx_hdr_ready;

        case (state_q)
            MUX_IDLE: begin
                if (request && !tx_hdr_valid_q) begin
                    hdr_load           = 1'b1;
                    sel_d              = grant;
                    hdr_ready_d[grant] = 1'b1;
                    tx_hdr_valid_d     = 1'b1;
                    state_d            = MUX_FRAME;
                end
            end
            MUX_FRAME: begin
                if (cur_xfer && rx_tlast[sel_q]) begin
                    state_d = MUX_IDLE;
                end
            end
            default: state_d = MUX_IDLE;
        endcase

        // tready follows the output stage one cycle late
        if (state_d == MUX_FRAME) begin
            tready_d[sel_d] = ready_early;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q        <= MUX_IDLE;
            sel_q          <= '0;
            hdr_ready_q    <= '0;
            tready_q       <= '0;
            tx_hdr_valid_q <= 1'b0;
        end else begin
            state_q        <= state_d;
            sel_q          <= sel_d;
            hdr_ready_q    <= hdr_ready_d;
            tready_q       <= tready_d;
            tx_hdr_valid_q <= tx_hdr_valid_d;
        end
    end

    // header fields of the granted port
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            dest_mac_q <= rx_dest_mac[grant];
            src_mac_q  <= rx_src_mac[grant];
            type_q     <= rx_type[grant];
        end
    end

    assign busy         = (state_q == MUX_FRAME) | tx_hdr_valid_q;
    assign rx_hdr_ready = hdr_ready_q;
    assign rx_tready    = tready_q;
    assign tx_hdr_valid = tx_hdr_valid_q;
    assign tx_dest_mac  = dest_mac_q;
    assign tx_src_mac   = src_mac_q;
    assign tx_type      = type_q;

    assign beat_data  = rx_tdata[sel_q];
    assign beat_valid = cur_xfer;
    assign beat_last  = rx_tlast[sel_q];
    assign beat_user  = rx_tuser[sel_q];

    only_locked_port_ready: assert property (
        @(posedge clk) disable iff (rst)
        |rx_tready |-> (state_q == MUX_FRAME) && (rx_tready == (`ETH_PORTS'(1) << sel_q))
    ) else $error("tready raised on a port that is not locked");

    tx_header_held: assert property (
        @(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=>
            tx_hdr_valid && $stable({tx_dest_mac, tx_src_mac, tx_type})
    ) else $error("tx header changed before it was accepted");

endmodule

`default_nettype wire

//--- design/eth_skid_buffer.sv
/*
 * Payload skid buffer
 * output register plus one spare register, upstream ready is
 * computed a cycle early so the source can register it
 */

`timescale 1ns/1ns
`default_nettype none

module eth_skid_buffer #(
    parameter int WIDTH = 10
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             ready_early,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    logic [WIDTH-1:0] out_data_q, temp_data_q;
    logic             out_valid_q, temp_valid_q;
    logic             ready_q;

    // room next cycle if the output drains, both are empty, or the spare stays free
    assign ready_early = out_ready
                       | (~temp_valid_q & ~out_valid_q)
                       | (~temp_valid_q & ~in_valid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_q      <= 1'b0;
            out_valid_q  <= 1'b0;
            temp_valid_q <= 1'b0;
        end else begin
            ready_q <= ready_early;
            if (ready_q) begin
                if (out_ready || !out_valid_q) begin
                    out_valid_q <= in_valid;
                end else begin
                    temp_valid_q <= in_valid;
                end
            end else if (out_ready) begin
                // drain the spare into the output
                out_valid_q  <= temp_valid_q;
                temp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready_q) begin
            if (out_ready || !out_valid_q) begin
                out_data_q <= in_data;
            end else begin
                temp_data_q <= in_data;
            end
        end else if (out_ready) begin
            out_data_q <= temp_data_q;
        end
    end

    assign out_data  = out_data_q;
    assign out_valid = out_valid_q;

    no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |-> !(out_valid_q && temp_valid_q)
    ) else $error("beat arrived with both registers full");

endmodule

`default_nettype wire

//--- design/eth_mux_top.sv
/*
 * Four-port Ethernet frame multiplexer
 * round-robin arbiter, frame mux and payload skid buffer
 */

`timescale 1ns/1ns
`default_nettype none

`include "eth_mux_defs.svh"

module eth_mux_top
    import eth_mux_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst,
    // receive ports
    input  logic [`ETH_PORTS-1:0]                  rx_hdr_valid,
    output logic [`ETH_PORTS-1:0]                  rx_hdr_ready,
    input  logic [`ETH_PORTS-1:0][`ETH_MAC_W-1:0]  rx_dest_mac,
    input  logic [`ETH_PORTS-1:0][`ETH_MAC_W-1:0]  rx_src_mac,
    input  logic [`ETH_PORTS-1:0][`ETH_TYPE_W-1:0] rx_type,
    input  logic [`ETH_PORTS-1:0][`ETH_DATA_W-1:0] rx_tdata,
    input  logic [`ETH_PORTS-1:0]                  rx_tvalid,
    output logic [`ETH_PORTS-1:0]                  rx_tready,
    input  logic [`ETH_PORTS-1:0]                  rx_tlast,
    input  logic [`ETH_PORTS-1:0]                  rx_tuser,
    // transmit port
    output logic                                   tx_hdr_valid,
    input  logic                                   tx_hdr_ready,
    output logic [`ETH_MAC_W-1:0]                  tx_dest_mac,
    output logic [`ETH_MAC_W-1:0]                  tx_src_mac,
    output logic [`ETH_TYPE_W-1:0]                 tx_type,
    output logic [`ETH_DATA_W-1:0]                 tx_tdata,
    output logic                                   tx_tvalid,
    input  logic                                   tx_tready,
    output logic                                   tx_tlast,
    output logic                                   tx_tuser
);

    port_idx_t              grant;
    logic                   request;
    logic                   busy;
    logic [`ETH_DATA_W-1:0] beat_data;
    logic                   beat_valid;
    logic                   beat_last;
    logic                   beat_user;
    logic                   ready_early;

    eth_port_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .hdr_valid (rx_hdr_valid),
        .busy      (busy),
        .grant     (grant),
        .request   (request)
    );

    eth_frame_mux u_frame_mux (
        .clk          (clk),
        .rst          (rst),
        .grant        (grant),
        .request      (request),
        .busy         (busy),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_dest_mac  (rx_dest_mac),
        .rx_src_mac   (rx_src_mac),
        .rx_type      (rx_type),
        .rx_tdata     (rx_tdata),
        .rx_tvalid    (rx_tvalid),
        .rx_tready    (rx_tready),
        .rx_tlast     (rx_tlast),
        .rx_tuser     (rx_tuser),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_dest_mac  (tx_dest_mac),
        .tx_src_mac   (tx_src_mac),
        .tx_type      (tx_type),
        .beat_data    (beat_data),
        .beat_valid   (beat_valid),
        .beat_last    (beat_last),
        .beat_user    (beat_user),
        .ready_early  (ready_early)
    );

    // beat is {user, last, data}
    eth_skid_buffer #(
        .WIDTH (`ETH_DATA_W + 2)
    ) u_skid_buffer (
        .clk         (clk),
        .rst         (rst),
        .in_data     ({beat_user, beat_last, beat_data}),
        .in_valid    (beat_valid),
        .ready_early (ready_early),
        .out_data    ({tx_tuser, tx_tlast, tx_tdata}),
        .out_valid   (tx_tvalid),
        .out_ready   (tx_tready)
    );

endmodule

`default_nettype wire

//--- sim/tb_eth_mux.sv
/*
 * Testbench for the four-port Ethernet frame mux
 * per-port frame drivers, random transmit back-pressure and a
 * round-robin scoreboard on the transmit side
 */

`timescale 1ns/1ns
`default_nettype none

`include "eth_mux_defs.svh"

module tb_eth_mux
    import eth_mux_pkg::*;
();

    localparam int NF         = 9;
    localparam int WAIT_LIMIT = 2000;

    typedef struct packed {
        port_idx_t              port;
        logic [`ETH_MAC_W-1:0]  dest;
        logic [`ETH_MAC_W-1:0]  src;
        logic [`ETH_TYPE_W-1:0] etype;
        logic [7:0]             len;
        logic [`ETH_DATA_W-1:0] first;
        logic                   user;
    } frame_t;

    logic                                   clk;
    logic                                   rst;
    logic [`ETH_PORTS-1:0]                  rx_hdr_valid;
    logic [`ETH_PORTS-1:0]                  rx_hdr_ready;
    logic [`ETH_PORTS-1:0][`ETH_MAC_W-1:0]  rx_dest_mac;
    logic [`ETH_PORTS-1:0][`ETH_MAC_W-1:0]  rx_src_mac;
    logic [`ETH_PORTS-1:0][`ETH_TYPE_W-1:0] rx_type;
    logic [`ETH_PORTS-1:0][`ETH_DATA_W-1:0] rx_tdata;
    logic [`ETH_PORTS-1:0]                  rx_tvalid;
    logic [`ETH_PORTS-1:0]                  rx_tready;
    logic [`ETH_PORTS-1:0]                  rx_tlast;
    logic [`ETH_PORTS-1:0]                  rx_tuser;
    logic                                   tx_hdr_valid;
    logic                                   tx_hdr_ready;
    logic [`ETH_MAC_W-1:0]                  tx_dest_mac;
    logic [`ETH_MAC_W-1:0]                  tx_src_mac;
    logic [`ETH_TYPE_W-1:0]                 tx_type;
    logic [`ETH_DATA_W-1:0]                 tx_tdata;
    logic                                   tx_tvalid;
    logic                                   tx_tready;
    logic                                   tx_tlast;
    logic                                   tx_tuser;

    frame_t frames [NF];
    int     pending [`ETH_PORTS][$];
    int     order[$];
    int     hdr_idx    = 0;
    int     beat_frame = 0;
    int     beat_cnt   = 0;
    int     errors     = 0;
    int     timeouts   = 0;
    integer seed       = 32'h97d8_2360;

    eth_mux_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random back-pressure on both transmit handshakes
    always @(posedge clk) begin : backpressure
        logic [31:0] rnd;
        rnd = $random(seed);
        tx_tready    <= (rnd[1:0] != 2'b00);
        tx_hdr_ready <= rnd[2] | rnd[3];
    end

    task automatic compare_field(input string name, input logic [63:0] expected,
                                 input logic [63:0] observed);
        assert (observed === expected) else begin
            $display("CHECK FAILED at %0t: %s expected %0h observed %0h",
                     $time, name, expected, observed);
            errors++;
        end
    endtask

    // arbiter starts at port 0 and serves the next port with frames left
    task automatic predict_order();
        int        next_of [`ETH_PORTS];
        port_idx_t last;
        port_idx_t cand;
        logic      found;
        last = port_idx_t'(`ETH_PORTS - 1);
        for (int p = 0; p < `ETH_PORTS; p++) begin
            next_of[p] = 0;
        end
        repeat (NF) begin
            found = 1'b0;
            for (int k = 1; k <= `ETH_PORTS; k++) begin
                cand = port_idx_t'(last + k);
                if (!found && next_of[cand] < pending[cand].size()) begin
                    found = 1'b1;
                    last  = cand;
                end
            end
            order.push_back(pending[last][next_of[last]]);
            next_of[last]++;
        end
    endtask

    // header first, then payload bytes counting up from the first byte
    task automatic drive_port(input int p);
        frame_t f;
        int     waited;
        logic   seen;
        while (pending[p].size() > 0) begin
            f = frames[pending[p].pop_front()];
            rx_hdr_valid[p] <= 1'b1;
            rx_dest_mac[p]  <= f.dest;
            rx_src_mac[p]   <= f.src;
            rx_type[p]      <= f.etype;
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < WAIT_LIMIT) begin
                @(posedge clk);
                waited++;
                seen = rx_hdr_ready[p];
            end
            rx_hdr_valid[p] <= 1'b0;
            if (!seen) begin
                $display("timeout: port %0d header was never accepted", p);
                timeouts++;
                return;
            end
            for (int b = 0; b < f.len; b++) begin
                rx_tdata[p]  <= `ETH_DATA_W'(f.first + b);
                rx_tvalid[p] <= 1'b1;
                rx_tlast[p]  <= (b == f.len - 1);
                rx_tuser[p]  <= f.user;
                waited = 0;
                seen   = 1'b0;
                while (!seen && waited < WAIT_LIMIT) begin
                    @(posedge clk);
                    waited++;
                    seen = rx_tready[p];
                end
                if (!seen) begin
                    $display("timeout: port %0d payload byte %0d was never taken", p, b);
                    timeouts++;
                    rx_tvalid[p] <= 1'b0;
                    return;
                end
            end
            rx_tvalid[p] <= 1'b0;
            rx_tlast[p]  <= 1'b0;
        end
    endtask

    // handshakes are sampled mid-cycle, where both sides are settled
    always @(negedge clk) begin : tx_monitor
        frame_t f;
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            assert (hdr_idx < NF) else begin
                $display("extra tx header seen at %0t", $time);
                errors++;
            end
            if (hdr_idx < NF) begin
                f = frames[order[hdr_idx]];
                compare_field("tx_dest_mac", f.dest, tx_dest_mac);
                compare_field("tx_src_mac", f.src, tx_src_mac);
                compare_field("tx_type", f.etype, tx_type);
                hdr_idx++;
            end
        end
        if (!rst && tx_tvalid && tx_tready) begin
            assert (beat_frame < NF) else begin
                $display("extra payload byte seen at %0t", $time);
                errors++;
            end
            if (beat_frame < NF) begin
                f = frames[order[beat_frame]];
                compare_field("tx_tdata", `ETH_DATA_W'(f.first + beat_cnt), tx_tdata);
                compare_field("tx_tlast", (beat_cnt == f.len - 1), tx_tlast);
                compare_field("tx_tuser", f.user, tx_tuser);
                beat_cnt++;
                if (beat_cnt == f.len) begin
                    beat_cnt = 0;
                    beat_frame++;
                end
            end
        end
    end

    initial begin : main
        int waited;
        rst          = 1'b1;
        rx_hdr_valid = '0;
        rx_dest_mac  = '0;
        rx_src_mac   = '0;
        rx_type      = '0;
        rx_tdata     = '0;
        rx_tvalid    = '0;
        rx_tlast     = '0;
        rx_tuser     = '0;
        tx_hdr_ready = 1'b0;
        tx_tready    = 1'b0;

        // port, dest, src, ethertype, length, first byte, user
        frames[0] = '{2'd0, 48'h0200_0000_0a01, 48'h0200_0000_b001, 16'h0800, 8'd5, 8'h10, 1'b0};
        frames[1] = '{2'd1, 48'h0200_0000_0a02, 48'h0200_0000_b002, 16'h86dd, 8'd3, 8'h20, 1'b1};
        frames[2] = '{2'd2, 48'hffff_ffff_ffff, 48'h0200_0000_b003, 16'h0806, 8'd8, 8'h30, 1'b0};
        frames[3] = '{2'd3, 48'h0200_0000_0a04, 48'h0200_0000_b004, 16'h88f7, 8'd1, 8'h40, 1'b0};
        frames[4] = '{2'd0, 48'h0200_0000_0a05, 48'h0200_0000_b001, 16'h0800, 8'd2, 8'h50, 1'b1};
        frames[5] = '{2'd2, 48'h0200_0000_0a06, 48'h0200_0000_b003, 16'h8100, 8'd6, 8'hfc, 1'b0};
        frames[6] = '{2'd1, 48'h0200_0000_0a07, 48'h0200_0000_b002, 16'h0800, 8'd4, 8'h60, 1'b0};
        frames[7] = '{2'd0, 48'h0200_0000_0a08, 48'h0200_0000_b001, 16'h88cc, 8'd7, 8'h70, 1'b0};
        frames[8] = '{2'd0, 48'h0200_0000_0a09, 48'h0200_0000_b001, 16'h0800, 8'd1, 8'h80, 1'b1};

        for (int i = 0; i < NF; i++) begin
            pending[frames[i].port].push_back(i);
        end
        predict_order();

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // nothing offered yet
        repeat (4) begin
            @(negedge clk);
            compare_field("rx_hdr_ready", '0, rx_hdr_ready);
            compare_field("rx_tready", '0, rx_tready);
            compare_field("tx_hdr_valid", '0, tx_hdr_valid);
            compare_field("tx_tvalid", '0, tx_tvalid);
        end

        @(posedge clk);
        fork
            drive_port(0);
            drive_port(1);
            drive_port(2);
            drive_port(3);
        join

        waited = 0;
        while ((hdr_idx < NF || beat_frame < NF) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (hdr_idx < NF || beat_frame < NF) begin
            $display("timeout: only %0d headers and %0d payloads reached tx",
                     hdr_idx, beat_frame);
            timeouts++;
        end
        // a few idle cycles to catch stray output
        repeat (10) @(posedge clk);

        $display("errors: %0d check, %0d timeout", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+design
design/eth_mux_pkg.sv
design/eth_port_arbiter.sv
design/eth_frame_mux.sv
design/eth_skid_buffer.sv
design/eth_mux_top.sv
sim/tb_eth_mux.sv

//--- Bender.yml
package:
  name: eth_mux

sources:
  - include_dirs:
      - design
    files:
      - design/eth_mux_pkg.sv
      - design/eth_port_arbiter.sv
      - design/eth_frame_mux.sv
      - design/eth_skid_buffer.sv
      - design/eth_mux_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_eth_mux.sv
